// ==== design/dfu_pkg.sv ====
//----------------------------------------------------------
// shared widths, multiplier latency and opcode encoding
// for the elastic integer operator unit
//----------------------------------------------------------
package dfu_pkg;

	// operand and result width
	localparam int DATA_W = 32;

	// register stages from operand accept to result valid
	localparam int MUL_LATENCY = 4;

	typedef logic [DATA_W-1:0] word_t;

	//----------------------------------------------------------
	// opcodes carried on channel a
	//----------------------------------------------------------
	typedef enum logic [4:0] {
		OP_ADD,
		OP_SUB,
		OP_MUL,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SHL,
		OP_LSHR,
		OP_ASHR,
		// compares return their result in bit 0
		OP_EQ,
		OP_NE,
		OP_UGT,
		OP_UGE,
		OP_ULT,
		OP_ULE,
		OP_SGT,
		OP_SGE,
		OP_SLT,
		OP_SLE
	} alu_op_t;

endpackage

// ==== design/dfu_top.sv ====
//----------------------------------------------------------
// top level that wires the operand join, ALU, multiplier
// and output buffer behind plain handshake ports
//----------------------------------------------------------
module dfu_top (
	input  logic             clk,
	input  logic             rst,
	input  logic             a_valid,
	input  dfu_pkg::alu_op_t a_op,
	input  dfu_pkg::word_t   a_data,
	output logic             a_ready,
	input  logic             b_valid,
	input  dfu_pkg::word_t   b_data,
	output logic             b_ready,
	output logic             res_valid,
	output dfu_pkg::word_t   res_data,
	input  logic             res_ready
);
	import dfu_pkg::*;

	operand_if alu_tok ();
	operand_if mul_tok ();

	logic  alu_valid;
	word_t alu_data;
	logic  alu_ready;
	logic  mul_valid;
	word_t mul_data;
	logic  mul_ready;
	logic  mul_busy;

	operand_join join0 (
		.a_valid  (a_valid),
		.a_op     (a_op),
		.a_data   (a_data),
		.b_valid  (b_valid),
		.b_data   (b_data),
		.a_ready  (a_ready),
		.b_ready  (b_ready),
		.mul_busy (mul_busy),
		.alu_tok  (alu_tok.src),
		.mul_tok  (mul_tok.src)
	);

	int_alu alu0 (
		.tok       (alu_tok.dst),
		.alu_valid (alu_valid),
		.alu_data  (alu_data),
		.alu_ready (alu_ready)
	);

	mul_pipe mul0 (
		.clk       (clk),
		.rst       (rst),
		.tok       (mul_tok.dst),
		.mul_valid (mul_valid),
		.mul_data  (mul_data),
		.mul_ready (mul_ready),
		.mul_busy  (mul_busy)
	);

	result_buffer rbuf0 (
		.clk       (clk),
		.rst       (rst),
		.alu_valid (alu_valid),
		.alu_data  (alu_data),
		.alu_ready (alu_ready),
		.mul_valid (mul_valid),
		.mul_data  (mul_data),
		.mul_ready (mul_ready),
		.res_valid (res_valid),
		.res_data  (res_data),
		.res_ready (res_ready)
	);

endmodule

// ==== design/int_alu.sv ====
//----------------------------------------------------------
// single-cycle add, sub, logic, shift and compare datapath
// handshake passes straight through to the result port
//----------------------------------------------------------
module int_alu (
	operand_if.dst         tok,
	output logic           alu_valid,
	output dfu_pkg::word_t alu_data,
	input  logic           alu_ready
);
	import dfu_pkg::*;

	// signed views of the same operand bits
	logic signed [DATA_W-1:0] sa;
	logic signed [DATA_W-1:0] sb;

	assign sa = tok.a;
	assign sb = tok.b;

	assign alu_valid = tok.valid;
	assign tok.ready = alu_ready;

	//----------------------------------------------------------
	// result cone
	//----------------------------------------------------------
	always_comb begin
		alu_data = '0;
		case (tok.op)
			OP_ADD:  alu_data = tok.a + tok.b;
			OP_SUB:  alu_data = tok.a - tok.b;
			OP_AND:  alu_data = tok.a & tok.b;
			OP_OR:   alu_data = tok.a | tok.b;
			OP_XOR:  alu_data = tok.a ^ tok.b;
			// the full 32-bit amount counts so 32 and up shifts everything out
			OP_SHL:  alu_data = tok.a << tok.b;
			OP_LSHR: alu_data = tok.a >> tok.b;
			// large amounts leave pure sign fill
			OP_ASHR: alu_data = word_t'(sa >>> tok.b);
			// compares set bit 0 only
			OP_EQ:   alu_data[0] = (tok.a == tok.b);
			OP_NE:   alu_data[0] = (tok.a != tok.b);
			OP_UGT:  alu_data[0] = (tok.a > tok.b);
			OP_UGE:  alu_data[0] = (tok.a >= tok.b);
			OP_ULT:  alu_data[0] = (tok.a < tok.b);
			OP_ULE:  alu_data[0] = (tok.a <= tok.b);
			OP_SGT:  alu_data[0] = (sa > sb);
			OP_SGE:  alu_data[0] = (sa >= sb);
			OP_SLT:  alu_data[0] = (sa < sb);
			OP_SLE:  alu_data[0] = (sa <= sb);
			// multiply never reaches this path
			default: alu_data = '0;
		endcase
	end

endmodule

// ==== design/mul_pipe.sv ====
//----------------------------------------------------------
// four-stage stallable multiplier that keeps the low 32
// product bits and feeds a one-entry opaque output slot
//----------------------------------------------------------
module mul_pipe (
	input  logic           clk,
	input  logic           rst,
	operand_if.dst         tok,
	output logic           mul_valid,
	output dfu_pkg::word_t mul_data,
	input  logic           mul_ready,
	output logic           mul_busy
);
	import dfu_pkg::*;

	logic                   ce;
	logic                   accept;
	logic [MUL_LATENCY-1:0] stage_valid;
	word_t                  op_a;
	word_t                  op_b;
	word_t                  prod_q [1:MUL_LATENCY-1];
	logic                   slot_valid;
	word_t                  slot_data;
	logic [$clog2(MUL_LATENCY+2)-1:0] in_flight;

	// whole pipe advances whenever the slot can take a word
	assign ce = ~slot_valid | mul_ready;
	assign tok.ready = ce;
	assign accept = tok.valid & ce;

	//----------------------------------------------------------
	// product stages
	//----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (ce) begin
			op_a <= tok.a;
			op_b <= tok.b;
			prod_q[1] <= op_a * op_b;
			for (int i = 2; i < MUL_LATENCY; i++) begin
				prod_q[i] <= prod_q[i-1];
			end
		end
	end

	// valid line tracks the product stages one for one
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			stage_valid <= '0;
		end else if (ce) begin
			stage_valid <= {stage_valid[MUL_LATENCY-2:0], accept};
		end
	end

	//----------------------------------------------------------
	// opaque output slot
	//----------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			slot_valid <= 1'b0;
		end else if (ce) begin
			slot_valid <= stage_valid[MUL_LATENCY-1];
		end
	end

	always_ff @(posedge clk) begin
		if (ce) begin
			slot_data <= prod_q[MUL_LATENCY-1];
		end
	end

	assign mul_valid = slot_valid;
	assign mul_data = slot_data;
	assign mul_busy = (|stage_valid) | slot_valid;

	// multiplies accepted but not yet delivered
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			in_flight <= '0;
		end else begin
			case ({accept, mul_valid & mul_ready})
				2'b10: in_flight <= in_flight + 1'b1;
				2'b01: in_flight <= in_flight - 1'b1;
				default: in_flight <= in_flight;
			endcase
		end
	end

	// a product only ever leaves for a token taken in earlier
	a_no_phantom: assert property (@(posedge clk) disable iff (rst)
		mul_valid |-> (in_flight != '0))
		else $error("mul_valid without an accepted multiply");

endmodule

// ==== design/operand_if.sv ====
//----------------------------------------------------------
// joined operand token with valid/ready handshake
// src drives the token, dst consumes it
//----------------------------------------------------------
interface operand_if;
	import dfu_pkg::*;

	logic    valid;
	logic    ready;
	alu_op_t op;
	word_t   a;
	word_t   b;

	// op, a and b hold while valid is high and ready is low
	modport src (
		output valid,
		output op,
		output a,
		output b,
		input  ready
	);

	modport dst (
		input  valid,
		input  op,
		input  a,
		input  b,
		output ready
	);

endinterface

// ==== design/operand_join.sv ====
//----------------------------------------------------------
// joins operand channels a and b into one token and steers
// it to the ALU or the multiplier by opcode class
//----------------------------------------------------------
module operand_join (
	input  logic             a_valid,
	input  dfu_pkg::alu_op_t a_op,
	input  dfu_pkg::word_t   a_data,
	input  logic             b_valid,
	input  dfu_pkg::word_t   b_data,
	output logic             a_ready,
	output logic             b_ready,
	input  logic             mul_busy,
	operand_if.src           alu_tok,
	operand_if.src           mul_tok
);
	import dfu_pkg::*;

	logic join_valid;
	logic is_mul;
	logic alu_open;
	logic dest_ready;

	// a token exists only with both operands present
	assign join_valid = a_valid & b_valid;
	assign is_mul = (a_op == OP_MUL);

	// alu results would overtake a multiply still in flight
	assign alu_open = ~mul_busy;

	assign mul_tok.valid = join_valid & is_mul;
	assign mul_tok.op = a_op;
	assign mul_tok.a = a_data;
	assign mul_tok.b = b_data;

	assign alu_tok.valid = join_valid & ~is_mul & alu_open;
	assign alu_tok.op = a_op;
	assign alu_tok.a = a_data;
	assign alu_tok.b = b_data;

	//----------------------------------------------------------
	// both channels are consumed together or not at all
	//----------------------------------------------------------
	assign dest_ready = is_mul ? mul_tok.ready : (alu_tok.ready & alu_open);

	assign a_ready = join_valid & dest_ready;
	assign b_ready = join_valid & dest_ready;

endmodule

// ==== design/result_buffer.sv ====
//----------------------------------------------------------
// merges ALU and multiplier results into a transparent
// one-entry slot that drives the result channel
//----------------------------------------------------------
module result_buffer (
	input  logic           clk,
	input  logic           rst,
	input  logic           alu_valid,
	input  dfu_pkg::word_t alu_data,
	output logic           alu_ready,
	input  logic           mul_valid,
	input  dfu_pkg::word_t mul_data,
	output logic           mul_ready,
	output logic           res_valid,
	output dfu_pkg::word_t res_data,
	input  logic           res_ready
);
	import dfu_pkg::*;

	logic  in_valid;
	word_t in_data;
	logic  full;
	word_t slot_data;

	// the join never lets both sources be valid at once
	assign in_valid = alu_valid | mul_valid;
	assign in_data = mul_valid ? mul_data : alu_data;

	assign alu_ready = ~full;
	assign mul_ready = ~full;

	//----------------------------------------------------------
	// slot fills on a stalled result, drains on res_ready
	//----------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			full <= 1'b0;
		end else if (full) begin
			full <= ~res_ready;
		end else begin
			full <= in_valid & ~res_ready;
		end
	end

	always_ff @(posedge clk) begin
		if (~full) begin
			slot_data <= in_data;
		end
	end

	// empty slot passes the input through in the same cycle
	assign res_valid = full | in_valid;
	assign res_data = full ? slot_data : in_data;

	a_one_source: assert property (@(posedge clk) disable iff (rst)
		!(alu_valid && mul_valid))
		else $error("alu and mul results valid together");

	a_hold_data: assert property (@(posedge clk) disable iff (rst)
		(res_valid && !res_ready) |=> (res_valid && $stable(res_data)))
		else $error("res_data changed under back-pressure");

endmodule

// ==== list.f ====
+incdir+verif
design/dfu_pkg.sv
design/operand_if.sv
design/operand_join.sv
design/int_alu.sv
design/mul_pipe.sv
design/result_buffer.sv
design/dfu_top.sv
verif/tb_dfu.sv

// ==== verif/dfu_ref.svh ====
//----------------------------------------------------------
// expected-result model and value check that the operator
// unit testbench includes inside its module
//----------------------------------------------------------
`ifndef DFU_REF_SVH
`define DFU_REF_SVH

// expected result of one token
function automatic word_t ref_result(input alu_op_t op, input word_t x, input word_t y);
	logic [2*DATA_W-1:0] prod;
	logic big;
	// amounts of a full word or more clear the value (or sign fill)
	big = (y >= DATA_W);
	prod = {{DATA_W{1'b0}}, x} * {{DATA_W{1'b0}}, y};
	case (op)
		OP_ADD:  return x + y;
		OP_SUB:  return x - y;
		OP_MUL:  return prod[DATA_W-1:0];
		OP_AND:  return x & y;
		OP_OR:   return x | y;
		OP_XOR:  return x ^ y;
		OP_SHL:  return big ? '0 : (x << y[$clog2(DATA_W)-1:0]);
		OP_LSHR: return big ? '0 : (x >> y[$clog2(DATA_W)-1:0]);
		OP_ASHR: begin
			if (big) begin
				return {DATA_W{x[DATA_W-1]}};
			end
			return word_t'($signed(x) >>> y[$clog2(DATA_W)-1:0]);
		end
		OP_EQ:   return word_t'(x == y);
		OP_NE:   return word_t'(x != y);
		OP_UGT:  return word_t'(x > y);
		OP_UGE:  return word_t'(x >= y);
		OP_ULT:  return word_t'(x < y);
		OP_ULE:  return word_t'(x <= y);
		OP_SGT:  return word_t'($signed(x) > $signed(y));
		OP_SGE:  return word_t'($signed(x) >= $signed(y));
		OP_SLT:  return word_t'($signed(x) < $signed(y));
		OP_SLE:  return word_t'($signed(x) <= $signed(y));
		default: return '0;
	endcase
endfunction

// compares one observed value with its expected value
task automatic check_value(input string name, input word_t got, input word_t exp, output bit ok);
	ok = (got === exp);
	n_checks++;
	if (!ok) begin
		n_errors++;
		$display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
	end
endtask

`endif

// ==== verif/tb_dfu.sv ====
//----------------------------------------------------------
// testbench for the operator unit that checks directed and
// random tokens in order against a reference model
//----------------------------------------------------------
module tb_dfu;
	import dfu_pkg::*;

	localparam int PERIOD = 8;
	localparam int DRV = 1;
	localparam int NUM_TOKENS = 300;
	localparam int SEED = 32'h5678_f31f;
	localparam int LIMIT = NUM_TOKENS * (MUL_LATENCY + 16);
	localparam int DRAIN_MAX = 64;

	logic    clk = 1'b0;
	logic    rst;
	logic    a_valid;
	alu_op_t a_op;
	word_t   a_data;
	logic    a_ready;
	logic    b_valid;
	word_t   b_data;
	logic    b_ready;
	logic    res_valid;
	word_t   res_data;
	logic    res_ready;

	// scoreboard queues with one entry per accepted token
	word_t exp_q [$];
	int    acc_q [$];
	bit    mul_q [$];
	int    xfer_q [$];

	int cyc = 0;
	int n_checks = 0;
	int n_errors = 0;
	int n_tokens = 0;
	int join_checks = 0;
	int join_errs = 0;
	int sent = 0;
	bit pending = 1'b0;
	bit timing_mode = 1'b0;

	`include "dfu_ref.svh"

	dfu_top dut0 (
		.clk       (clk),
		.rst       (rst),
		.a_valid   (a_valid),
		.a_op      (a_op),
		.a_data    (a_data),
		.a_ready   (a_ready),
		.b_valid   (b_valid),
		.b_data    (b_data),
		.b_ready   (b_ready),
		.res_valid (res_valid),
		.res_data  (res_data),
		.res_ready (res_ready)
	);

	always #(PERIOD/2) clk = ~clk;

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	//----------------------------------------------------------
	// scoreboard pushes on accept and compares on transfer
	//----------------------------------------------------------
	always @(posedge clk) begin
		bit    ok;
		word_t exp_w;
		int    acc_c;
		bit    was_mul;
		if (a_valid && b_valid && a_ready) begin
			exp_q.push_back(ref_result(a_op, a_data, b_data));
			acc_q.push_back(cyc);
			mul_q.push_back(a_op == OP_MUL);
			n_tokens++;
		end
		// both channels move together
		join_checks++;
		check_value("b_ready", word_t'(b_ready), word_t'(a_ready), ok);
		if (!ok) begin
			join_errs++;
		end
		if (a_valid !== b_valid) begin
			check_value("a_ready", word_t'(a_ready), '0, ok);
			if (!ok) begin
				join_errs++;
			end
		end
		if (res_valid && res_ready) begin
			xfer_q.push_back(cyc);
			if (exp_q.size() == 0) begin
				report_failure("a result left the unit with no accepted token behind it");
			end else begin
				exp_w = exp_q.pop_front();
				acc_c = acc_q.pop_front();
				was_mul = mul_q.pop_front();
				check_value("res_data", res_data, exp_w, ok);
				// mul output rises at edge accept+MUL_LATENCY and transfers one edge later
				if (timing_mode) begin
					check_value("latency", word_t'(cyc - acc_c),
						word_t'(was_mul ? MUL_LATENCY + 1 : 0), ok);
				end
			end
		end
	end

	task automatic report_failure(input string msg);
		n_errors++;
		$display("error at t=%0t, %s", $time, msg);
	endtask

	task automatic end_test(input string name, input int c0, input int e0);
		$display("test %-12s checks %0d errors %0d", name, n_checks - c0, n_errors - e0);
	endtask

	task automatic expect_idle();
		bit ok;
		check_value("res_valid", word_t'(res_valid), '0, ok);
		check_value("a_ready", word_t'(a_ready), '0, ok);
		check_value("b_ready", word_t'(b_ready), '0, ok);
	endtask

	// presents one token with each valid rising after its own gap
	task automatic send_token(input alu_op_t op, input word_t x, input word_t y,
			input int gap_a, input int gap_b);
		int n;
		bit taken;
		n = 0;
		taken = 1'b0;
		sent++;
		pending = 1'b1;
		a_op = op;
		a_data = x;
		b_data = y;
		a_valid = (gap_a == 0);
		b_valid = (gap_b == 0);
		while (!taken) begin
			@(posedge clk);
			taken = a_valid && b_valid && a_ready;
			#DRV;
			n++;
			if (n >= gap_a) a_valid = 1'b1;
			if (n >= gap_b) b_valid = 1'b1;
		end
		a_valid = 1'b0;
		b_valid = 1'b0;
		pending = 1'b0;
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < DRAIN_MAX) begin
			@(posedge clk);
			#DRV;
			n++;
		end
		if (exp_q.size() != 0) begin
			report_failure($sformatf("%0d accepted tokens never produced a result",
				exp_q.size()));
			exp_q.delete();
			acc_q.delete();
			mul_q.delete();
		end
	endtask

	function automatic word_t mixed_operand();
		word_t corners [6];
		corners = '{32'h0, 32'hffff_ffff, 32'h8000_0000, 32'd31, 32'd32, 32'd33};
		if ($urandom_range(0, 3) == 0) begin
			return corners[$urandom_range(0, 5)];
		end
		return $urandom();
	endfunction

	function automatic int valid_gap();
		return ($urandom_range(0, 2) == 0) ? $urandom_range(1, 3) : 0;
	endfunction

	task automatic random_token(output alu_op_t op, output word_t x, output word_t y);
		if ($urandom_range(0, 3) == 0) begin
			op = OP_MUL;
		end else begin
			op = alu_op_t'($urandom_range(0, 18));
		end
		x = mixed_operand();
		y = mixed_operand();
		// shifts mostly get amounts around the word width
		if ((op == OP_SHL || op == OP_LSHR || op == OP_ASHR) && $urandom_range(0, 1) == 1) begin
			y = $urandom_range(0, 40);
		end
	endtask

	//----------------------------------------------------------
	// tests
	//----------------------------------------------------------
	task automatic sweep_alu_ops();
		word_t xs [8];
		word_t ys [8];
		int c0;
		int e0;
		c0 = n_checks;
		e0 = n_errors;
		xs = '{32'd5, 32'hffff_ffff, 32'h0, 32'h8000_0000,
			32'h1234_5678, 32'h8765_4321, 32'h7fff_ffff, 32'h55};
		ys = '{32'd3, 32'h1, 32'h1, 32'hffff_ffff, 32'd31, 32'd32, 32'd33, 32'h55};
		for (int k = 0; k <= 18; k++) begin
			if (alu_op_t'(k) != OP_MUL) begin
				for (int i = 0; i < 8; i++) begin
					send_token(alu_op_t'(k), xs[i], ys[i], 0, 0);
				end
			end
		end
		wait_drain();
		end_test("alu_ops", c0, e0);
	endtask

	task automatic time_multiplies();
		word_t xs [4];
		word_t ys [4];
		int c0;
		int e0;
		int n;
		bit ok;
		c0 = n_checks;
		e0 = n_errors;
		xs = '{32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff, 32'hdead_beef};
		ys = '{32'hffff_ffff, 32'd2, 32'h7fff_ffff, 32'h0001_1000};
		// a lone multiply through an idle pipeline
		send_token(OP_MUL, 32'h1234_5678, 32'h9abc_def0, 0, 0);
		wait_drain();
		for (int i = 0; i < 4; i++) begin
			send_token(OP_MUL, xs[i], ys[i], 0, 0);
		end
		wait_drain();
		n = xfer_q.size();
		check_value("mul_spacing", word_t'(xfer_q[n-1] - xfer_q[n-4]), word_t'(3), ok);
		end_test("mul_timing", c0, e0);
	endtask

	task automatic stress_random_order();
		alu_op_t op;
		word_t x;
		word_t y;
		int c0;
		int e0;
		int x0;
		bit ok;
		bit tokens_done;
		c0 = n_checks;
		e0 = n_errors;
		x0 = xfer_q.size();
		tokens_done = 1'b0;
		fork
			begin
				for (int i = 0; i < NUM_TOKENS; i++) begin
					random_token(op, x, y);
					send_token(op, x, y, valid_gap(), valid_gap());
				end
				tokens_done = 1'b1;
			end
			begin
				while (!tokens_done) begin
					@(posedge clk);
					#DRV;
					res_ready = ($urandom_range(0, 3) != 0);
				end
			end
		join
		res_ready = 1'b1;
		wait_drain();
		check_value("results", word_t'(xfer_q.size() - x0), word_t'(NUM_TOKENS), ok);
		end_test("random_order", c0, e0);
	endtask

	task automatic exercise_join();
		int x0;
		bit ok;
		x0 = xfer_q.size();
		// one channel waits alone for a few cycles each time
		send_token(OP_XOR, 32'hf0f0_1234, 32'h0ff0_4321, 0, 5);
		send_token(OP_MUL, 32'h0000_1234, 32'h0000_5678, 6, 0);
		wait_drain();
		join_checks++;
		check_value("results", word_t'(xfer_q.size() - x0), word_t'(2), ok);
		if (!ok) begin
			join_errs++;
		end
		$display("test %-12s checks %0d errors %0d", "join_rule", join_checks, join_errs);
	endtask

	initial begin : watchdog
		while (cyc < LIMIT) begin
			@(posedge clk);
		end
		if (pending) begin
			$display("token %0d was still waiting to be accepted at the timeout", sent);
		end
		$display("timeout, run did not finish within %0d cycles", LIMIT);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		int c0;
		int e0;
		void'($urandom(SEED));
		rst = 1'b1;
		a_valid = 1'b0;
		a_op = OP_ADD;
		a_data = '0;
		b_valid = 1'b0;
		b_data = '0;
		res_ready = 1'b0;
		c0 = n_checks;
		e0 = n_errors;
		repeat (10) begin
			@(posedge clk);
			expect_idle();
		end
		#DRV;
		rst = 1'b0;
		@(posedge clk);
		expect_idle();
		#DRV;
		end_test("reset_state", c0, e0);
		res_ready = 1'b1;
		timing_mode = 1'b1;
		sweep_alu_ops();
		time_multiplies();
		timing_mode = 1'b0;
		stress_random_order();
		exercise_join();
		$display("tokens %0d, checks %0d, errors %0d", n_tokens, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule
